//--- rtl/i2s_pkg.sv
/* Widths and counter sizes shared by the I2S capture RTL and its testbench.
   Modules pull these in with a wildcard import in their header. */

package i2s_pkg;

    // ##############################
    // Audio word and frame sizes
    // ##############################

    // Bits kept per slot; extra slot bits are ignored.
    localparam int sample_width = 16;

    // Bit counter inside a slot, must reach sample_width.
    localparam int bit_cnt_width = 5;

    // Left word in the upper half, right word in the lower half.
    localparam int frame_width = 2 * sample_width;

    // ##############################
    // Output port bookkeeping
    // ##############################

    // Saturating count of frames lost to back-pressure.
    localparam int drop_cnt_width = 8;

    // The counter is frozen at this value once reached.
    localparam logic [drop_cnt_width-1:0] drop_cnt_max = '1;

    // Handy constants for the slot bit counter.
    localparam logic [bit_cnt_width-1:0] bit_cnt_one  = bit_cnt_width'(1);
    localparam logic [bit_cnt_width-1:0] bit_cnt_full = bit_cnt_width'(sample_width);

endpackage

//--- rtl/i2s_rx.sv
/* I2S slave receiver on the serial bit clock. Emits one word per ws slot
   with a one-cycle left or right valid pulse, MSB first, one-bit I2S delay. */
`timescale 1ns/1ps

module i2s_rx import i2s_pkg::*;
(
    input  logic                    sck,
    input  logic                    rst_n,

    input  logic                    ws,
    input  logic                    sda,

    output logic [sample_width-1:0] word,
    output logic                    left_valid,
    output logic                    right_valid
);

    logic [1:0]                 ws_d;       // Newest ws in bit 0.
    logic                       ws_edge;
    logic                       in_slot;    // Set by the first ws edge after reset.
    logic [bit_cnt_width-1:0]   bit_cnt;
    logic [sample_width-1:0]    shift_q;

    // ##############################
    // ws history and transition
    // ##############################

    always_ff @(posedge sck or negedge rst_n)
    begin
        if (!rst_n)
            ws_d <= 2'b00;
        else
            ws_d <= {ws_d[0], ws};
    end

    assign ws_edge = ws_d[0] ^ ws_d[1];    // High for one cycle per slot change.

    // ##############################
    // Bit counter and shifter
    // ##############################

    // The MSB is taken in the same cycle the transition is seen,
    // so the counter restarts at one and stops at a full word.
    always_ff @(posedge sck or negedge rst_n)
    begin
        if (!rst_n)
        begin
            bit_cnt <= bit_cnt_full;        // Idle until the first slot.
            shift_q <= '0;
        end
        else if (ws_edge)
        begin
            bit_cnt <= bit_cnt_one;
            shift_q <= {{(sample_width-1){1'b0}}, sda};    // MSB of new slot.
        end
        else if (bit_cnt < bit_cnt_full)
        begin
            bit_cnt <= bit_cnt + 1'b1;
            shift_q <= {shift_q[sample_width-2:0], sda};
        end
    end

    // ##############################
    // Word output and channel tag
    // ##############################

    // The stretch before the first ws edge is no slot and yields no word.
    always_ff @(posedge sck or negedge rst_n)
    begin
        if (!rst_n)
        begin
            in_slot     <= 1'b0;
            word        <= '0;
            left_valid  <= 1'b0;
            right_valid <= 1'b0;
        end
        else
        begin
            if (ws_edge)
                in_slot <= 1'b1;
            if (ws_edge && in_slot)
                word <= shift_q;            // Ending slot is complete here.
            left_valid  <= ws_edge & in_slot & ~ws_d[1];  // Old level low means left.
            right_valid <= ws_edge & in_slot &  ws_d[1];
        end
    end

    // A word only leaves after a slot long enough for all its bits.
    a_word_complete: assert property (
        @(posedge sck) disable iff (!rst_n)
        (left_valid || right_valid) |-> $past(bit_cnt) == bit_cnt_full
    );

endmodule

//--- rtl/stereo_pairer.sv
/* Joins each left word with the right word that follows it into a stereo
   frame. A right word with no left word before it is discarded. */
`timescale 1ns/1ps

module stereo_pairer import i2s_pkg::*;
(
    input  logic                    sck,
    input  logic                    rst_n,

    input  logic [sample_width-1:0] word,
    input  logic                    left_valid,
    input  logic                    right_valid,

    output logic [sample_width-1:0] frame_left,
    output logic [sample_width-1:0] frame_right,
    output logic                    frame_valid
);

    logic [sample_width-1:0] left_hold;    // Latest left word.
    logic                    have_left;

    // ##############################
    // Left word holding
    // ##############################

    always_ff @(posedge sck or negedge rst_n)
    begin
        if (!rst_n)
            left_hold <= '0;
        else if (left_valid)
            left_hold <= word;              // A newer left replaces the old one.
    end

    always_ff @(posedge sck or negedge rst_n)
    begin
        if (!rst_n)
            have_left <= 1'b0;
        else if (left_valid)
            have_left <= 1'b1;
        else if (right_valid)
            have_left <= 1'b0;              // Consumed or discarded.
    end

    // ##############################
    // Frame emission
    // ##############################

    always_ff @(posedge sck or negedge rst_n)
    begin
        if (!rst_n)
        begin
            frame_left  <= '0;
            frame_right <= '0;
            frame_valid <= 1'b0;
        end
        else
        begin
            frame_valid <= right_valid & have_left;
            if (right_valid && have_left)
            begin
                frame_left  <= left_hold;
                frame_right <= word;        // Word still holds the right sample.
            end
        end
    end

    // Pairing assumes one channel pulse at a time.
    a_valid_exclusive: assert property (
        @(posedge sck) disable iff (!rst_n)
        !(left_valid && right_valid)
    );

endmodule

//--- rtl/frame_handshake.sv
/* Single-frame output register with a four-phase req/ack handshake.
   Frames that arrive while a transfer is in progress are dropped and counted. */
`timescale 1ns/1ps

module frame_handshake import i2s_pkg::*;
(
    input  logic                      sck,
    input  logic                      rst_n,

    input  logic [sample_width-1:0]   frame_left,
    input  logic [sample_width-1:0]   frame_right,
    input  logic                      frame_valid,

    input  logic                      ack,
    output logic                      req,
    output logic [sample_width-1:0]   out_left,
    output logic [sample_width-1:0]   out_right,
    output logic [drop_cnt_width-1:0] drop_count
);

    typedef enum logic [1:0] {
        st_idle,
        st_request,
        st_release
    } hs_state_t;

    hs_state_t              state;
    logic                   accept;
    logic [frame_width-1:0] frame_q;    // Left in the upper half.

    // Idle means both req and ack low.
    assign accept = frame_valid && (state == st_idle) && !ack;

    // ##############################
    // Handshake FSM
    // ##############################

    always_ff @(posedge sck or negedge rst_n)
    begin
        if (!rst_n)
            state <= st_idle;
        else
        begin
            case (state)
                st_idle:    if (accept) state <= st_request;
                st_request: if (ack)    state <= st_release;   // Drop req.
                st_release: if (!ack)   state <= st_idle;      // Wait ack low.
                default:                state <= st_idle;
            endcase
        end
    end

    assign req = (state == st_request);

    // ##############################
    // Frame register and drops
    // ##############################

    always_ff @(posedge sck or negedge rst_n)
    begin
        if (!rst_n)
        begin
            frame_q    <= '0;
            drop_count <= '0;
        end
        else if (accept)
            frame_q <= {frame_left, frame_right};
        else if (frame_valid && drop_count != drop_cnt_max)
            drop_count <= drop_count + 1'b1;    // Busy, frame is lost.
    end

    assign out_left  = frame_q[frame_width-1:sample_width];
    assign out_right = frame_q[sample_width-1:0];

    // Data held steady for the whole request phase.
    a_data_stable: assert property (
        @(posedge sck) disable iff (!rst_n)
        req && $past(req) |-> $stable(out_left) && $stable(out_right)
    );

    // A new request only starts once the consumer has released ack.
    a_req_rise_ack_low: assert property (
        @(posedge sck) disable iff (!rst_n)
        $rose(req) |-> !ack
    );

endmodule

//--- rtl/i2s_capture_top.sv
/* I2S capture path: receiver, left/right pairing and req/ack output stage.
   Runs entirely on the serial bit clock sck. */
`timescale 1ns/1ps

module i2s_capture_top import i2s_pkg::*;
(
    input  logic                      sck,
    input  logic                      rst_n,

    // Serial audio input.
    input  logic                      ws,
    input  logic                      sda,

    // Consumer port.
    input  logic                      ack,
    output logic                      req,
    output logic [sample_width-1:0]   out_left,
    output logic [sample_width-1:0]   out_right,
    output logic [drop_cnt_width-1:0] drop_count
);

    // ##############################
    // Stage wiring
    // ##############################

    logic [sample_width-1:0] word;
    logic                    left_valid;
    logic                    right_valid;

    logic [sample_width-1:0] frame_left;
    logic [sample_width-1:0] frame_right;
    logic                    frame_valid;

    i2s_rx u_rx (
        .sck         (sck),
        .rst_n       (rst_n),
        .ws          (ws),
        .sda         (sda),
        .word        (word),
        .left_valid  (left_valid),
        .right_valid (right_valid)
    );

    stereo_pairer u_pairer (
        .sck         (sck),
        .rst_n       (rst_n),
        .word        (word),
        .left_valid  (left_valid),
        .right_valid (right_valid),
        .frame_left  (frame_left),
        .frame_right (frame_right),
        .frame_valid (frame_valid)
    );

    frame_handshake u_handshake (
        .sck         (sck),
        .rst_n       (rst_n),
        .frame_left  (frame_left),
        .frame_right (frame_right),
        .frame_valid (frame_valid),
        .ack         (ack),
        .req         (req),
        .out_left    (out_left),
        .out_right   (out_right),
        .drop_count  (drop_count)
    );

endmodule

//--- tb/capture_checker.sv
/* Scoreboard for the I2S capture testbench. Holds the expected stereo frames,
   checks the req/ack port, the drop counter and the reset state. */
`timescale 1ns/1ps

module capture_checker import i2s_pkg::*;
(
    input  logic                      sck,
    input  logic                      rst_n,

    // DUT consumer port, watched only.
    input  logic                      req,
    input  logic                      ack,
    input  logic [sample_width-1:0]   out_left,
    input  logic [sample_width-1:0]   out_right,
    input  logic [drop_cnt_width-1:0] drop_count,

    // Expected pairs from the source.
    input  logic                      exp_valid,
    input  logic [sample_width-1:0]   exp_left,
    input  logic [sample_width-1:0]   exp_right,
    input  logic                      slow_phase,
    input  logic                      end_check,

    output int                        error_count,
    output int                        frame_count,
    output int                        skip_count
);

    logic [frame_width-1:0]  exp_q[$];      // Left word in the upper half.
    logic [frame_width-1:0]  last_pushed;
    logic [frame_width-1:0]  last_seen;
    logic [sample_width-1:0] left_q;
    logic [sample_width-1:0] right_q;
    logic                    rst_q;
    logic                    req_q;
    logic                    ack_q;
    logic                    slow_q;
    logic                    end_done;
    int                      exp_drops;

    initial
    begin
        error_count = 0;
        frame_count = 0;
        skip_count  = 0;
        last_pushed = '0;
        last_seen   = '0;
        rst_q       = 1'b0;
        req_q       = 1'b0;
        ack_q       = 1'b0;
        slow_q      = 1'b0;
        end_done    = 1'b0;
    end

    task automatic report_value(input string name, input logic [31:0] expected,
                                input logic [31:0] actual);
        $display("** Error at %0t ns: %s expected %0h, got %0h", $time, name, expected, actual);
        error_count++;
    endtask

    task automatic report_failure(input string what);
        $display("Check failed at %0t ns: %s", $time, what);
        error_count++;
    endtask

    // ##############################
    // Frame matching
    // ##############################

    // Entries ahead of the match were lost to back-pressure.
    task automatic match_frame(input logic [frame_width-1:0] got);
        int idx;
        int i;
        idx = -1;
        for (i = 0; i < exp_q.size(); i++)
        begin
            if (idx < 0 && exp_q[i] == got)
                idx = i;
        end
        if (exp_q.size() == 0)
            report_failure("frame delivered while no pair was expected");
        else if (idx < 0)
        begin
            report_value("out_left", exp_q[0][frame_width-1:sample_width],
                         got[frame_width-1:sample_width]);
            report_value("out_right", exp_q[0][sample_width-1:0], got[sample_width-1:0]);
        end
        else
        begin
            for (i = 0; i <= idx; i++)
                exp_q.delete(0);
            skip_count += idx;
        end
    endtask

    // ##############################
    // Per-cycle checks
    // ##############################

    always @(posedge sck)
    begin
        if (!rst_n || !rst_q)
        begin
            if (req !== 1'b0)
                report_value("req", 0, req);         // Also the first cycle out of reset.
            if (drop_count !== '0)
                report_value("drop_count", 0, drop_count);
        end
        else
        begin
            if (exp_valid)
            begin
                exp_q.push_back({exp_left, exp_right});
                last_pushed = {exp_left, exp_right};
            end
            if (req && !req_q)
            begin
                if (ack)
                    report_failure("req rose while ack was still high");
                match_frame({out_left, out_right});
                last_seen = {out_left, out_right};
                frame_count++;
            end
            if (!req && req_q && !ack_q)
                report_failure("req fell before ack was seen high");
            if (req && req_q)
            begin
                if (out_left !== left_q)
                    report_value("out_left", left_q, out_left);     // Changed under req.
                if (out_right !== right_q)
                    report_value("out_right", right_q, out_right);
            end
            if (slow_phase && !slow_q && drop_count !== '0)
                report_value("drop_count", 0, drop_count);     // Fast phase lost frames.
            if (end_check && !end_done)
            begin
                exp_drops = (skip_count > drop_cnt_max) ? drop_cnt_max : skip_count;
                if (exp_q.size() != 0)
                    report_failure($sformatf("%0d expected frames never delivered",
                                             exp_q.size()));
                if (last_seen[frame_width-1:sample_width] !== last_pushed[frame_width-1:sample_width])
                    report_value("last out_left", last_pushed[frame_width-1:sample_width],
                                 last_seen[frame_width-1:sample_width]);
                if (last_seen[sample_width-1:0] !== last_pushed[sample_width-1:0])
                    report_value("last out_right", last_pushed[sample_width-1:0],
                                 last_seen[sample_width-1:0]);
                if (drop_count !== drop_cnt_width'(exp_drops))
                    report_value("drop_count", exp_drops, drop_count);
                if (skip_count == 0)
                    report_failure("slow consumer phase caused no dropped frames");
                end_done = 1'b1;
            end
        end
        rst_q   = rst_n;
        req_q   = req;
        ack_q   = ack;
        left_q  = out_left;
        right_q = out_right;
        slow_q  = slow_phase;
    end

endmodule

//--- tb/tb_i2s_capture.sv
/* Testbench for the I2S capture path. Sends random slots from an LFSR,
   plays a fast or slow req/ack consumer and lets the checker score frames. */
`timescale 1ns/1ps

module tb_i2s_capture import i2s_pkg::*;
();

    localparam int slot_count     = 200;
    localparam int pair_count     = slot_count / 2;
    localparam int fast_pairs     = 30;         // Followed by a slow phase and a last fast one.
    localparam int slow_pairs     = 40;
    localparam int timeout_cycles = slot_count * 25 + 2000;

    logic                      sck;
    logic                      rst_n;
    logic                      ws;
    logic                      sda;
    logic                      ack;
    logic                      req;
    logic [sample_width-1:0]   out_left;
    logic [sample_width-1:0]   out_right;
    logic [drop_cnt_width-1:0] drop_count;

    logic                      exp_valid;
    logic [sample_width-1:0]   exp_left;
    logic [sample_width-1:0]   exp_right;
    logic                      slow_phase;
    logic                      end_check;
    int                        ack_delay;
    int                        error_count;
    int                        frame_count;
    int                        skip_count;
    int                        cycle_count;
    logic [31:0]               lfsr_state;

    i2s_capture_top dut (
        .sck        (sck),
        .rst_n      (rst_n),
        .ws         (ws),
        .sda        (sda),
        .ack        (ack),
        .req        (req),
        .out_left   (out_left),
        .out_right  (out_right),
        .drop_count (drop_count)
    );

    capture_checker u_checker (
        .sck         (sck),
        .rst_n       (rst_n),
        .req         (req),
        .ack         (ack),
        .out_left    (out_left),
        .out_right   (out_right),
        .drop_count  (drop_count),
        .exp_valid   (exp_valid),
        .exp_left    (exp_left),
        .exp_right   (exp_right),
        .slow_phase  (slow_phase),
        .end_check   (end_check),
        .error_count (error_count),
        .frame_count (frame_count),
        .skip_count  (skip_count)
    );

    initial
    begin
        sck = 1'b0;
        forever
            #5 sck = ~sck;
    end

    // ##############################
    // Random bits
    // ##############################

    // Galois form with taps x^32 + x^22 + x^2 + x + 1.
    function automatic logic next_bit();
        logic out;
        out = lfsr_state[0];
        lfsr_state = lfsr_state >> 1;
        if (out)
            lfsr_state = lfsr_state ^ 32'h8020_0003;
        return out;
    endfunction

    function automatic logic [31:0] random_bits(input int count);
        logic [31:0] value;
        int          n;
        value = '0;
        for (n = 0; n < count; n++)
            value = {value[30:0], next_bit()};
        return value;
    endfunction

    // ##############################
    // I2S source
    // ##############################

    // Starts on a clock edge; the slot lasts sample_width plus 1 to 8 cycles.
    task automatic send_slot(input logic level, input logic [sample_width-1:0] data);
        int pad;
        int b;
        pad = 1 + random_bits(3);
        ws  <= level;
        sda <= next_bit();                  // Still the previous slot's bit.
        @(posedge sck);
        for (b = sample_width - 1; b >= 0; b--)
        begin
            sda <= data[b];                 // MSB first.
            @(posedge sck);
        end
        repeat (pad - 1)
        begin
            sda <= next_bit();
            @(posedge sck);
        end
    endtask

    task automatic push_pair(input logic [sample_width-1:0] left,
                             input logic [sample_width-1:0] right);
        exp_left  <= left;
        exp_right <= right;
        exp_valid <= 1'b1;
    endtask

    // One-cycle strobe into the expected queue.
    always @(posedge sck)
    begin
        if (exp_valid)
            exp_valid <= 1'b0;
    end

    initial
    begin : stimulus
        int                      pair;
        logic                    slow;
        logic [sample_width-1:0] left_word;
        logic [sample_width-1:0] right_word;
        lfsr_state = 32'hd8d1;
        rst_n      = 1'b0;
        ws         = 1'b0;
        sda        = 1'b0;
        ack        = 1'b0;
        exp_valid  = 1'b0;
        exp_left   = '0;
        exp_right  = '0;
        slow_phase = 1'b0;
        end_check  = 1'b0;
        ack_delay  = 0;
        repeat (16) @(posedge sck);
        rst_n <= 1'b1;
        repeat (4) @(posedge sck);          // Idle lead-in with ws and sda low.
        // A lone right slot that no left word precedes.
        right_word = random_bits(sample_width);
        send_slot(1'b1, right_word);
        for (pair = 1; pair <= pair_count; pair++)
        begin
            slow = (pair > fast_pairs) && (pair <= fast_pairs + slow_pairs);
            slow_phase <= slow;
            if (slow)
                ack_delay <= 40 + random_bits(7) % 81;
            else
                ack_delay <= random_bits(2);
            left_word  = random_bits(sample_width);
            send_slot(1'b0, left_word);
            right_word = random_bits(sample_width);
            send_slot(1'b1, right_word);
            push_pair(left_word, right_word);
        end
        ws  <= 1'b0;                        // Closes the last right slot.
        sda <= 1'b0;
        @(posedge sck);
        while (!req)
            @(posedge sck);
        while (req || ack)
            @(posedge sck);
        end_check <= 1'b1;
        repeat (2) @(posedge sck);
        $display("errors: %0d, frames: %0d, skipped: %0d, drop_count: %0d",
                 error_count, frame_count, skip_count, drop_count);
        if (error_count == 0)
            $display("sim passed");
        else
            $display("sim failed");
        $finish;
    end

    // ##############################
    // Consumer and timeout
    // ##############################

    initial
    begin : consumer
        @(posedge rst_n);
        forever
        begin
            @(posedge sck);
            if (req)
            begin
                repeat (ack_delay) @(posedge sck);
                ack <= 1'b1;
                @(posedge sck);
                while (req)
                    @(posedge sck);
                ack <= 1'b0;                // Four-phase release.
            end
        end
    end

    initial
    begin
        cycle_count = 0;
        while (cycle_count < timeout_cycles)
        begin
            @(posedge sck);
            cycle_count = cycle_count + 1;
        end
        $display("Timeout: the last frame was not delivered within %0d cycles", timeout_cycles);
        $display("sim failed");
        $finish;
    end

endmodule

//--- verilog.f
rtl/i2s_pkg.sv
rtl/i2s_rx.sv
rtl/stereo_pairer.sv
rtl/frame_handshake.sv
rtl/i2s_capture_top.sv
tb/capture_checker.sv
tb/tb_i2s_capture.sv

//--- Bender.yml
package:
  name: i2s_capture

sources:
  - files:
      - rtl/i2s_pkg.sv
      - rtl/i2s_rx.sv
      - rtl/stereo_pairer.sv
      - rtl/frame_handshake.sv
      - rtl/i2s_capture_top.sv
  - target: simulation
    files:
      - tb/capture_checker.sv
      - tb/tb_i2s_capture.sv
